// ==== verilog/row_store_pkg.sv ====
`default_nettype none

package row_store_pkg;

  // ==============================
  // Data path widths
  // ==============================
  localparam int WORD_W = 32;
  localparam int BANKS  = 8;
  localparam int ROW_W  = WORD_W * BANKS;

  // ==============================
  // Host address map
  // ==============================
  // Bit 8 clear is memory, row in 7:3 and bank in 2:0
  localparam int HOST_ADDR_W = 9;

  localparam logic [HOST_ADDR_W-1:0] REG_CTRL   = 9'h100;
  localparam logic [HOST_ADDR_W-1:0] REG_CONFIG = 9'h101;
  localparam logic [HOST_ADDR_W-1:0] REG_STATUS = 9'h102;
  localparam logic [HOST_ADDR_W-1:0] REG_DIGEST = 9'h103;

endpackage

`default_nettype wire

// ==== verilog/row_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_store #(
  parameter int ROW_ADDR_W = 5
) (
  input  wire                               clk,

  input  wire                               mem_we,
  input  wire  [7:0]                        mem_addr,
  input  wire  [row_store_pkg::WORD_W-1:0]  mem_wr_data,
  output logic [row_store_pkg::WORD_W-1:0]  mem_rd_data,

  input  wire  [ROW_ADDR_W-1:0]             row_addr,
  output logic [row_store_pkg::ROW_W-1:0]   row_data
);

  import row_store_pkg::*;

  localparam int DEPTH      = 2 ** ROW_ADDR_W;
  localparam int BANK_SEL_W = $clog2(BANKS);

  logic [ROW_ADDR_W-1:0] host_row;
  logic [BANK_SEL_W-1:0] bank_sel;
  logic [BANK_SEL_W-1:0] bank_sel_q;

  logic [WORD_W-1:0] host_word [BANKS];
  logic [WORD_W-1:0] row_word  [BANKS];

  // ==============================
  // Host address split
  // ==============================
  assign host_row = mem_addr[ROW_ADDR_W+2:3];
  assign bank_sel = mem_addr[BANK_SEL_W-1:0];

  // ==============================
  // Banks
  // ==============================
  // Each bank is a plain two-port RAM, one port shared by host
  // writes and host reads, the other a read-only row port
  for (genvar b = 0; b < BANKS; b++)
  begin : g_bank
    logic [WORD_W-1:0] mem [DEPTH];
    logic              bank_we;

    assign bank_we = mem_we && (bank_sel == BANK_SEL_W'(b));

    always_ff @(posedge clk)
    begin
      if (bank_we)
      begin
        mem[host_row] <= mem_wr_data;
      end

      // Old data on a same-edge write
      host_word[b] <= mem[host_row];
      row_word[b]  <= mem[row_addr];
    end
  end

  // ==============================
  // Host read mux
  // ==============================
  // Bank select follows the read registers so the mux lines up with
  // the word they captured
  always_ff @(posedge clk)
  begin
    bank_sel_q <= bank_sel;
  end

  assign mem_rd_data = host_word[bank_sel_q];

  // ==============================
  // Row port
  // ==============================
  // Bank 7 ends up in the top bits
  always_comb
  begin
    for (int i = 0; i < BANKS; i++)
    begin
      row_data[i*WORD_W +: WORD_W] = row_word[i];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/host_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_decoder (
  input  wire                                   clk,
  input  wire                                   rst,

  input  wire                                   cs,
  input  wire                                   we,
  input  wire  [row_store_pkg::HOST_ADDR_W-1:0] addr,
  input  wire  [row_store_pkg::WORD_W-1:0]      wr_data,
  output logic [row_store_pkg::WORD_W-1:0]      rd_data,

  output logic                                  mem_we,
  output logic [7:0]                            mem_addr,
  output logic [row_store_pkg::WORD_W-1:0]      mem_wr_data,
  input  wire  [row_store_pkg::WORD_W-1:0]      mem_rd_data,

  output logic                                  start,
  output logic [4:0]                            first_row,
  output logic [5:0]                            row_count,
  input  wire                                   busy,
  input  wire                                   done,
  input  wire  [row_store_pkg::WORD_W-1:0]      digest
);

  import row_store_pkg::*;

  logic              rd_req;
  logic              reg_we;
  logic              start_ok;
  logic              done_flag_q;
  logic              fresh_q;
  logic              mem_class_q;
  logic [WORD_W-1:0] reg_word;
  logic [WORD_W-1:0] reg_rd_q;
  logic [WORD_W-1:0] hold_q;

  // ==============================
  // Access decode
  // ==============================
  assign rd_req      = cs && !we;
  assign reg_we      = cs && we && addr[8];
  assign mem_we      = cs && we && !addr[8];
  assign mem_addr    = addr[7:0];
  assign mem_wr_data = wr_data;

  // A second start is dropped until the scanner has gone idle again
  assign start_ok = reg_we && (addr == REG_CTRL) && wr_data[0] && !busy && !start;

  always_comb
  begin
    case (addr)
      REG_CONFIG: reg_word = {18'b0, row_count, 3'b0, first_row};
      REG_STATUS: reg_word = {30'b0, done_flag_q, busy || start};
      REG_DIGEST: reg_word = digest;
      default:    reg_word = '0;
    endcase
  end

  // ==============================
  // Control registers
  // ==============================
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      first_row   <= '0;
      row_count   <= '0;
      start       <= 1'b0;
      done_flag_q <= 1'b0;
      fresh_q     <= 1'b0;
      mem_class_q <= 1'b0;
    end
    else
    begin
      start   <= start_ok;
      fresh_q <= rd_req;

      if (rd_req)
      begin
        mem_class_q <= !addr[8];
      end

      if (reg_we && (addr == REG_CONFIG))
      begin
        first_row <= wr_data[4:0];
        row_count <= wr_data[13:8];
      end

      // Sticky done, cleared by the start that follows
      if (start_ok)
      begin
        done_flag_q <= 1'b0;
      end
      else if (done)
      begin
        done_flag_q <= 1'b1;
      end
    end
  end

  // ==============================
  // Read return
  // ==============================
  always_ff @(posedge clk)
  begin
    if (rd_req)
    begin
      reg_rd_q <= reg_word;
    end
    if (fresh_q)
    begin
      hold_q <= rd_data;
    end
  end

  // Fresh data for one cycle, then the captured copy
  assign rd_data = !fresh_q    ? hold_q :
                   mem_class_q ? mem_rd_data : reg_rd_q;

endmodule

`default_nettype wire

// ==== verilog/row_scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_scanner #(
  parameter int ROW_ADDR_W = 5
) (
  input  wire                              clk,
  input  wire                              rst,

  input  wire                              start,
  input  wire  [ROW_ADDR_W-1:0]            first_row,
  input  wire  [ROW_ADDR_W:0]              row_count,

  output logic [ROW_ADDR_W-1:0]            row_addr,
  input  wire  [row_store_pkg::ROW_W-1:0]  row_data,

  output logic                             busy,
  output logic                             done,
  output logic [row_store_pkg::WORD_W-1:0] digest
);

  import row_store_pkg::*;

  logic                  launch;
  logic                  issuing;
  logic                  vld_q;
  logic                  last_q;
  logic [ROW_ADDR_W-1:0] addr_q;
  logic [ROW_ADDR_W:0]   remain_q;
  logic [WORD_W-1:0]     acc_q;
  logic [WORD_W-1:0]     row_xor;
  logic [WORD_W-1:0]     fold;

  assign launch   = start && !busy;
  assign issuing  = busy && (remain_q != '0);
  assign row_addr = addr_q;

  // ==============================
  // Fold
  // ==============================
  always_comb
  begin
    row_xor = '0;
    for (int i = 0; i < BANKS; i++)
    begin
      row_xor = row_xor ^ row_data[i*WORD_W +: WORD_W];
    end
  end

  assign fold = {acc_q[WORD_W-2:0], acc_q[WORD_W-1]} ^ row_xor;

  // ==============================
  // Control
  // ==============================
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      done     <= 1'b0;
      vld_q    <= 1'b0;
      last_q   <= 1'b0;
      remain_q <= '0;
      digest   <= '0;
    end
    else
    begin
      done   <= 1'b0;
      vld_q  <= issuing;
      last_q <= issuing && (remain_q == (ROW_ADDR_W+1)'(1));

      if (launch)
      begin
        if (row_count == '0)
        begin
          done   <= 1'b1;
          digest <= '0;
        end
        else
        begin
          busy     <= 1'b1;
          remain_q <= row_count;
        end
      end

      if (issuing)
      begin
        remain_q <= remain_q - 1'b1;
      end

      // Last row is back from the store
      if (vld_q && last_q)
      begin
        busy   <= 1'b0;
        done   <= 1'b1;
        digest <= fold;
      end
    end
  end

  // Row address counter and accumulator
  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      addr_q <= first_row;
      acc_q  <= '0;
    end
    else
    begin
      if (issuing)
      begin
        addr_q <= addr_q + 1'b1;
      end
      if (vld_q)
      begin
        acc_q <= fold;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/row_digest_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_digest_top (
  input  wire                                   clk,
  input  wire                                   rst,

  input  wire                                   cs,
  input  wire                                   we,
  input  wire  [row_store_pkg::HOST_ADDR_W-1:0] addr,
  input  wire  [row_store_pkg::WORD_W-1:0]      wr_data,
  output logic [row_store_pkg::WORD_W-1:0]      rd_data,

  output logic                                  busy,
  output logic                                  done
);

  import row_store_pkg::*;

  // 32 rows
  localparam int ROW_ADDR_W = 5;

  logic                  mem_we;
  logic [7:0]            mem_addr;
  logic [WORD_W-1:0]     mem_wr_data;
  logic [WORD_W-1:0]     mem_rd_data;
  logic                  start;
  logic [ROW_ADDR_W-1:0] first_row;
  logic [ROW_ADDR_W:0]   row_count;
  logic [ROW_ADDR_W-1:0] row_addr;
  logic [ROW_W-1:0]      row_data;
  logic [WORD_W-1:0]     digest;

  // ==============================
  // Host side
  // ==============================
  host_decoder u_decoder (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .we          (we),
    .addr        (addr),
    .wr_data     (wr_data),
    .rd_data     (rd_data),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_rd_data (mem_rd_data),
    .start       (start),
    .first_row   (first_row),
    .row_count   (row_count),
    .busy        (busy),
    .done        (done),
    .digest      (digest)
  );

  // ==============================
  // Store and scanner
  // ==============================
  row_store #(
    .ROW_ADDR_W (ROW_ADDR_W)
  ) u_store (
    .clk         (clk),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_rd_data (mem_rd_data),
    .row_addr    (row_addr),
    .row_data    (row_data)
  );

  row_scanner #(
    .ROW_ADDR_W (ROW_ADDR_W)
  ) u_scanner (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .first_row (first_row),
    .row_count (row_count),
    .row_addr  (row_addr),
    .row_data  (row_data),
    .busy      (busy),
    .done      (done),
    .digest    (digest)
  );

endmodule

`default_nettype wire

// ==== sim/tb_row_digest.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_row_digest;

  import row_store_pkg::*;

  logic              clk;
  logic              rst;
  logic              cs;
  logic              we;
  logic [8:0]        addr;
  logic [31:0]       wr_data;
  logic [31:0]       rd_data;
  logic              busy;
  logic              done;

  logic [31:0]       shadow [256];
  int                errors;
  int                tests_passed;
  int                tests_failed;
  int                busy_cycles;
  int                done_pulses;
  int                seed_val;

  row_digest_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .cs      (cs),
    .we      (we),
    .addr    (addr),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .busy    (busy),
    .done    (done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Busy and done seen at each edge, cleared by the scan tasks
  always @(posedge clk)
  begin
    if (busy)
      busy_cycles++;
    if (done)
      done_pulses++;
  end

  initial
  begin
    #20000;
    $display("Watchdog expired: the tests did not finish within 20000 ns");
    $display("SIMULATION FAILED");
    $finish;
  end

  // ==============================
  // Host access
  // ==============================
  task automatic write_word(input logic [8:0] a, input logic [31:0] d);
    cs      = 1'b1;
    we      = 1'b1;
    addr    = a;
    wr_data = d;
    @(negedge clk);
    cs      = 1'b0;
    we      = 1'b0;
    if (!a[8])
      shadow[a[7:0]] = d;
  endtask

  task automatic read_word(input logic [8:0] a, output logic [31:0] d);
    cs   = 1'b1;
    we   = 1'b0;
    addr = a;
    @(negedge clk);
    d    = rd_data;
    cs   = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  // Rotate left by one, then fold in the XOR of the row's words
  task automatic expected_digest(input int first, input int count, output logic [31:0] acc);
    logic [31:0] x;
    int          r;
    acc = '0;
    for (int i = 0; i < count; i++)
    begin
      r = (first + i) % 32;
      x = '0;
      for (int b = 0; b < 8; b++)
        x = x ^ shadow[r*8 + b];
      acc = {acc[30:0], acc[31]} ^ x;
    end
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (!done)
    begin
      $display("%s: done never pulsed within 100 cycles of the start", name);
      errors++;
    end
  endtask

  task automatic run_scan(input string name, input int first, input int count, input bit extra);
    logic [31:0] got;
    logic [31:0] exp;
    busy_cycles = 0;
    done_pulses = 0;
    write_word(REG_CONFIG, {18'b0, 6'(count), 3'b0, 5'(first)});
    write_word(REG_CTRL, 32'h1);
    if (extra)
    begin
      // Second start lands while the first is still in progress
      write_word(REG_CTRL, 32'h1);
      read_word(REG_STATUS, got);
      check_value({name, " status while busy"}, 32'h1, got);
    end
    wait_done(name);
    repeat (4) @(negedge clk);
    expected_digest(first, count, exp);
    read_word(REG_DIGEST, got);
    check_value({name, " digest"}, exp, got);
    read_word(REG_STATUS, got);
    check_value({name, " status"}, 32'h2, got);
    check_value({name, " busy cycles"}, (count == 0) ? 0 : count + 1, busy_cycles);
    check_value({name, " done pulses"}, 1, done_pulses);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
    begin
      $display("Test %s: ok", name);
      tests_passed++;
    end
    else
    begin
      $display("Test %s: %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic check_reset_state();
    logic [31:0] got;
    int          e0;
    e0 = errors;
    read_word(REG_STATUS, got);
    check_value("reset status", 32'h0, got);
    read_word(REG_CONFIG, got);
    check_value("reset config", 32'h0, got);
    read_word(REG_DIGEST, got);
    check_value("reset digest", 32'h0, got);
    check_value("reset busy port", 32'h0, busy);
    check_value("reset done port", 32'h0, done);
    report_test("reset_state", e0);
  endtask

  task automatic check_readback();
    logic [8:0]  addrs [64];
    logic [31:0] got;
    int          e0;
    e0 = errors;
    for (int i = 0; i < 64; i++)
    begin
      addrs[i] = {1'b0, 5'($urandom % 32), 3'(i)};
      write_word(addrs[i], $urandom);
    end
    for (int i = 0; i < 64; i++)
    begin
      read_word(addrs[i], got);
      check_value("readback", shadow[addrs[i][7:0]], got);
      // The read word has to stay on rd_data while the address moves on
      addr = addrs[(i + 1) % 64];
      @(negedge clk);
      check_value("readback hold", shadow[addrs[i][7:0]], rd_data);
    end
    report_test("readback", e0);
  endtask

  task automatic scan_single_row();
    int r;
    int e0;
    e0 = errors;
    r  = $urandom % 32;
    for (int b = 0; b < 8; b++)
      write_word({1'b0, 5'(r), 3'(b)}, $urandom);
    run_scan("single_row", r, 1, 1'b0);
    report_test("single_row", e0);
  endtask

  task automatic scan_full_and_wrap();
    int e0;
    e0 = errors;
    for (int a = 0; a < 256; a++)
      write_word({1'b0, 8'(a)}, $urandom);
    run_scan("full_scan", 0, 32, 1'b0);
    run_scan("wrap_scan", 28, 8, 1'b0);
    report_test("full_and_wrap", e0);
  endtask

  task automatic scan_zero_and_restart();
    int e0;
    e0 = errors;
    run_scan("zero_count", 9, 0, 1'b0);
    run_scan("restart", 3, 4, 1'b1);
    report_test("zero_and_restart", e0);
  endtask

  initial
  begin
    cs           = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wr_data      = '0;
    rst          = 1'b1;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed_val     = $urandom(32'h2468);
    repeat (2) @(negedge clk);
    rst = 1'b0;

    check_reset_state();
    check_readback();
    scan_single_row();
    scan_full_and_wrap();
    scan_zero_and_restart();

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/row_store_pkg.sv
verilog/row_store.sv
verilog/host_decoder.sv
verilog/row_scanner.sv
verilog/row_digest_top.sv
sim/tb_row_digest.sv
